// ==== merge_pkg.sv ====
// Shared sizes and packed types that every design file of the merge data generator imports

package merge_pkg;

    // ----------------------------------------
    // Default sizes
    // ----------------------------------------

    // Lane count and lane word width
    localparam int NUM_LANES_DEFAULT   = 4;
    localparam int LANE_DATA_W_DEFAULT = 16;

    // Entries per lane FIFO
    localparam int FIFO_DEPTH_DEFAULT  = 8;

    // Packets allowed in flight downstream
    localparam int OUT_CREDITS_DEFAULT = 4;

    localparam int BEAT_COUNT_W        = 8;

    // ----------------------------------------
    // Packet types
    // ----------------------------------------

    typedef logic [LANE_DATA_W_DEFAULT-1:0] lane_word_t;

    // One word arriving on a lane
    typedef struct packed {
        logic       valid;
        lane_word_t payload;
    } lane_packet_t;

    // Job configuration sent in answer to a setup request
    typedef struct packed {
        logic                         valid;
        logic [BEAT_COUNT_W-1:0]      beat_count;
        logic [NUM_LANES_DEFAULT-1:0] lane_enable;
    } merge_config_t;

    // Merged beat with the word of lane i in slot i
    typedef struct packed {
        logic                                 valid;
        lane_word_t [NUM_LANES_DEFAULT-1:0]   payload;
    } request_packet_t;

endpackage

// ==== lane_fifo.sv ====
// Generic synchronous FIFO with a show-ahead head word that each merge lane instantiates
`timescale 1ns/100ps

module lane_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic     ap_clk,
    input  logic     areset_generator,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    // Overflow and underflow requests are dropped here
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // Head word is visible without read latency
    assign dout = mem[rd_ptr];

    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== lane_input_stage.sv ====
// Input side of the merge generator that buffers every lane and pops the enabled lanes together
`timescale 1ns/100ps

module lane_input_stage #(
    parameter int NUM_LANES  = merge_pkg::NUM_LANES_DEFAULT,
    parameter int FIFO_DEPTH = merge_pkg::FIFO_DEPTH_DEFAULT
) (
    input  logic                   ap_clk,
    input  logic                   areset_generator,
    input  merge_pkg::lane_packet_t lane_in [NUM_LANES],
    input  logic [NUM_LANES-1:0]   lane_enable,
    input  logic                   pop,
    output merge_pkg::lane_word_t  lane_words [NUM_LANES],
    output logic                   lanes_ready,
    output logic [NUM_LANES-1:0]   lane_credit
);

    import merge_pkg::*;

    logic [NUM_LANES-1:0] lane_empty;
    logic [NUM_LANES-1:0] lane_pop;

    // Only enabled lanes take part in a joint pop
    assign lane_pop = {NUM_LANES{pop}} & lane_enable;

    // Disabled lanes never hold up a beat
    assign lanes_ready = ~|(lane_enable & lane_empty);

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        lane_fifo #(
            .payload_t(lane_word_t),
            .DEPTH    (FIFO_DEPTH)
        ) i_lane_fifo (
            .ap_clk          (ap_clk),
            .areset_generator(areset_generator),
            .push            (lane_in[i].valid),
            .din             (lane_in[i].payload),
            .pop             (lane_pop[i]),
            .dout            (lane_words[i]),
            .empty           (lane_empty[i])
        );
    end

    // ----------------------------------------
    // Credit return to upstream
    // ----------------------------------------

    // One pulse per popped word in the cycle of the merged packet
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            lane_credit <= '0;
        end else begin
            lane_credit <= lane_pop;
        end
    end

endmodule

// ==== merge_control.sv ====
// Job control FSM of the merge generator that runs each job from descriptor to done
`timescale 1ns/100ps

module merge_control #(
    parameter int NUM_LANES = merge_pkg::NUM_LANES_DEFAULT
) (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  logic                    descriptor_valid,
    input  merge_pkg::merge_config_t config_in,
    input  logic                    lanes_ready,
    input  logic                    credit_available,
    output logic                    pop,
    output logic [NUM_LANES-1:0]    lane_enable,
    output logic                    config_request,
    output logic                    done
);

    import merge_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SETUP,
        ST_WAIT_CFG,
        ST_BUSY,
        ST_DONE
    } state_t;

    state_t                  state;
    state_t                  next_state;
    logic [BEAT_COUNT_W-1:0] beats_left;
    logic [NUM_LANES-1:0]    lane_enable_q;
    logic                    last_pop;

    // A beat goes out only with data on all enabled lanes and a free credit
    assign pop         = (state == ST_BUSY) & lanes_ready & credit_available;
    assign last_pop    = pop & (beats_left == BEAT_COUNT_W'(1));
    assign lane_enable = lane_enable_q;

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (descriptor_valid) begin
                    next_state = ST_SETUP;
                end
            end
            ST_SETUP: begin
                next_state = ST_WAIT_CFG;
            end
            ST_WAIT_CFG: begin
                // Empty job skips straight to done
                if (config_in.valid) begin
                    next_state = (config_in.beat_count == '0) ? ST_DONE : ST_BUSY;
                end
            end
            ST_BUSY: begin
                if (last_pop) begin
                    next_state = ST_DONE;
                end
            end
            ST_DONE: begin
                next_state = ST_IDLE;
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // ----------------------------------------
    // State, job registers and pulses
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state          <= ST_IDLE;
            beats_left     <= '0;
            lane_enable_q  <= '0;
            config_request <= 1'b0;
            done           <= 1'b0;
        end else begin
            state <= next_state;
            if (state == ST_WAIT_CFG && config_in.valid) begin
                beats_left    <= config_in.beat_count;
                lane_enable_q <= config_in.lane_enable;
            end else if (pop) begin
                beats_left <= beats_left - 1'b1;
            end
            // Request lands two cycles after the descriptor
            config_request <= (state == ST_SETUP);
            // Done follows the last packet by one cycle
            done           <= (state == ST_DONE);
        end
    end

endmodule

// ==== merge_output_stage.sv ====
// Output side of the merge generator that builds merged packets and counts downstream credits
`timescale 1ns/100ps

module merge_output_stage #(
    parameter int NUM_LANES   = merge_pkg::NUM_LANES_DEFAULT,
    parameter int OUT_CREDITS = merge_pkg::OUT_CREDITS_DEFAULT
) (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  logic                      pop,
    input  logic [NUM_LANES-1:0]      lane_enable,
    input  merge_pkg::lane_word_t     lane_words [NUM_LANES],
    input  logic                      out_credit,
    output logic                      credit_available,
    output merge_pkg::request_packet_t request_out
);

    import merge_pkg::*;

    localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);

    logic [CREDIT_W-1:0]        credit_count;
    lane_word_t [NUM_LANES-1:0] merged;

    // Each lane keeps its own slot and disabled slots read zero
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            merged[i] = lane_enable[i] ? lane_words[i] : '0;
        end
    end

    assign credit_available = (credit_count != '0);

    // ----------------------------------------
    // Packet register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            request_out.valid <= 1'b0;
        end else begin
            request_out.valid <= pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (pop) begin
            request_out.payload <= merged;
        end
    end

    // Spend on pop and regain on return, no change when both land together
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            credit_count <= CREDIT_W'(OUT_CREDITS);
        end else if (pop && !out_credit) begin
            credit_count <= credit_count - 1'b1;
        end else if (out_credit && !pop && credit_count != CREDIT_W'(OUT_CREDITS)) begin
            credit_count <= credit_count + 1'b1;
        end
    end

endmodule

// ==== merge_data_generator.sv ====
// Top level of the merge data generator that joins the lane FIFOs, job control and packet output
`timescale 1ns/100ps

module merge_data_generator #(
    parameter int NUM_LANES   = merge_pkg::NUM_LANES_DEFAULT,
    parameter int FIFO_DEPTH  = merge_pkg::FIFO_DEPTH_DEFAULT,
    parameter int OUT_CREDITS = merge_pkg::OUT_CREDITS_DEFAULT
) (
    input  logic                       ap_clk,
    input  logic                       areset_generator,
    input  logic                       descriptor_valid,
    input  merge_pkg::merge_config_t   config_in,
    input  merge_pkg::lane_packet_t    lane_in [NUM_LANES],
    input  logic                       out_credit,
    output logic [NUM_LANES-1:0]       lane_credit,
    output merge_pkg::request_packet_t request_out,
    output logic                       config_request,
    output logic                       done
);

    import merge_pkg::*;

    lane_word_t           lane_words [NUM_LANES];
    logic                 lanes_ready;
    logic                 credit_available;
    logic                 pop;
    logic [NUM_LANES-1:0] lane_enable;

    lane_input_stage #(
        .NUM_LANES (NUM_LANES),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_lane_input_stage (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .lane_in         (lane_in),
        .lane_enable     (lane_enable),
        .pop             (pop),
        .lane_words      (lane_words),
        .lanes_ready     (lanes_ready),
        .lane_credit     (lane_credit)
    );

    merge_control #(
        .NUM_LANES(NUM_LANES)
    ) i_merge_control (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .descriptor_valid(descriptor_valid),
        .config_in       (config_in),
        .lanes_ready     (lanes_ready),
        .credit_available(credit_available),
        .pop             (pop),
        .lane_enable     (lane_enable),
        .config_request  (config_request),
        .done            (done)
    );

    merge_output_stage #(
        .NUM_LANES  (NUM_LANES),
        .OUT_CREDITS(OUT_CREDITS)
    ) i_merge_output_stage (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .pop             (pop),
        .lane_enable     (lane_enable),
        .lane_words      (lane_words),
        .out_credit      (out_credit),
        .credit_available(credit_available),
        .request_out     (request_out)
    );

endmodule

// ==== merge_checker.sv ====
// Concurrent assertions on downstream credit use that are bound into the merge output stage
`timescale 1ns/100ps

module merge_checker #(
    parameter int OUT_CREDITS = merge_pkg::OUT_CREDITS_DEFAULT
) (
    input logic                               ap_clk,
    input logic                               areset_generator,
    input logic                               pop,
    input logic [$clog2(OUT_CREDITS + 1)-1:0] credit_count,
    input logic                               request_valid
);

    localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);

    // A packet is only sent when a credit was held in the pop cycle
    a_no_packet_without_credit: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        request_valid |-> ($past(credit_count) != '0)
    ) else $error("Packet sent while no downstream credit was held");

    a_credit_bound: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        credit_count <= CREDIT_W'(OUT_CREDITS)
    ) else $error("Downstream credit count above its limit");

    // Back to back packets need two pops in a row
    a_valid_needs_pops: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        (request_valid && $past(request_valid)) |-> ($past(pop, 1) && $past(pop, 2))
    ) else $error("Two valid packets without two pops");

endmodule

bind merge_output_stage merge_checker #(
    .OUT_CREDITS(OUT_CREDITS)
) i_merge_checker (
    .ap_clk          (ap_clk),
    .areset_generator(areset_generator),
    .pop             (pop),
    .credit_count    (credit_count),
    .request_valid   (request_out.valid)
);

// ==== tb_merge_data_generator.sv ====
// Testbench for the merge data generator that runs random jobs against a reference model
`timescale 1ns/100ps

module tb_merge_data_generator;

    import merge_pkg::*;

    localparam int NUM_LANES   = NUM_LANES_DEFAULT;
    localparam int FIFO_DEPTH  = FIFO_DEPTH_DEFAULT;
    localparam int OUT_CREDITS = OUT_CREDITS_DEFAULT;
    localparam int NUM_JOBS    = 6;
    localparam int MAX_BEATS   = 12;

    logic                 ap_clk = 1'b0;
    logic                 areset_generator;
    logic                 descriptor_valid;
    merge_config_t        config_in;
    lane_packet_t         lane_in [NUM_LANES];
    logic                 out_credit;
    logic [NUM_LANES-1:0] lane_credit;
    request_packet_t      request_out;
    logic                 config_request;
    logic                 done;

    // ----------------------------------------
    // Reference model state
    // ----------------------------------------
    integer               seed = 32'h6292_b383;
    lane_word_t           sent_q [NUM_LANES][$];
    int                   lane_credits [NUM_LANES];
    int                   words_to_send [NUM_LANES];
    int                   outstanding;
    int                   withhold;
    logic [NUM_LANES-1:0] job_mask;
    int                   job_beats;
    int                   beats_left;
    bit                   awaiting_done;
    bit                   packet_last_cycle;
    int                   request_count;

    always #50 ap_clk = ~ap_clk;

    merge_data_generator #(
        .NUM_LANES  (NUM_LANES),
        .FIFO_DEPTH (FIFO_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) i_merge_data_generator (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .descriptor_valid(descriptor_valid),
        .config_in       (config_in),
        .lane_in         (lane_in),
        .out_credit      (out_credit),
        .lane_credit     (lane_credit),
        .request_out     (request_out),
        .config_request  (config_request),
        .done            (done)
    );

    task automatic report_mismatch(input string what);
        $display("Mismatch at %0t ns: %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at the first failing check");
    endtask

    // Registered outputs are settled at the falling edge
    task automatic check_outputs();
        lane_word_t expected;
        bit         last_seen;
        last_seen = 1'b0;
        if (config_request) begin
            request_count++;
        end
        if (request_out.valid) begin
            assert (beats_left > 0)
                else report_failure("Packet arrived outside a configured job");
            outstanding++;
            assert (outstanding <= OUT_CREDITS)
                else report_failure("More packets in flight than downstream credits");
            for (int i = 0; i < NUM_LANES; i++) begin
                expected = '0;
                if (job_mask[i]) begin
                    assert (sent_q[i].size() > 0)
                        else report_failure($sformatf("Lane %0d popped with no word sent", i));
                    expected = sent_q[i].pop_front();
                end
                assert (request_out.payload[i] == expected)
                    else report_mismatch($sformatf("slot %0d got %h, expected %h",
                                                   i, request_out.payload[i], expected));
            end
            beats_left--;
            last_seen = (beats_left == 0);
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            assert (lane_credit[i] == (request_out.valid & job_mask[i]))
                else report_mismatch($sformatf("lane %0d credit is %0b", i, lane_credit[i]));
            if (lane_credit[i]) begin
                lane_credits[i]++;
            end
        end
        if (done) begin
            assert (awaiting_done && beats_left == 0)
                else report_failure("done pulsed without a finished job");
            assert (packet_last_cycle || job_beats == 0)
                else report_failure("done did not follow the last packet by one cycle");
            awaiting_done = 1'b0;
        end
        packet_last_cycle = last_seen;
    endtask

    // Upstream lanes spend credits and downstream returns them at random
    task automatic drive_traffic();
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_in[i] = '0;
            if (words_to_send[i] > 0 && lane_credits[i] > 0 && ($random(seed) & 3) != 0) begin
                lane_in[i].valid   = 1'b1;
                lane_in[i].payload = lane_word_t'($random(seed));
                sent_q[i].push_back(lane_in[i].payload);
                lane_credits[i]--;
                words_to_send[i]--;
            end
        end
        out_credit = 1'b0;
        if (withhold > 0) begin
            withhold--;
        end else if (($random(seed) & 15) == 0) begin
            withhold = 20 + ($random(seed) & 31);
        end else if (outstanding > 0 && ($random(seed) & 1) != 0) begin
            out_credit = 1'b1;
            outstanding--;
        end
    endtask

    task automatic tick();
        @(negedge ap_clk);
        check_outputs();
        drive_traffic();
    endtask

    task automatic run_job(input int beats, input logic [NUM_LANES-1:0] mask);
        int cycles;
        int delay;
        int expected_requests;
        expected_requests = request_count + 1;
        tick();
        descriptor_valid = 1'b1;
        cycles = 0;
        do begin
            tick();
            cycles++;
            descriptor_valid = 1'b0;
            config_in        = '0;
            // Early configuration with a bogus mask must be ignored
            if (cycles == 1) begin
                config_in.valid       = 1'b1;
                config_in.lane_enable = ~mask;
            end
        end while (!config_request && cycles < 8);
        assert (config_request) else report_failure("Timeout waiting for config_request");
        assert (cycles == 2)
            else report_mismatch($sformatf("config_request came after %0d cycles, expected 2",
                                           cycles));
        delay = $random(seed) & 3;
        for (int d = 0; d < delay; d++) begin
            tick();
        end
        config_in.valid       = 1'b1;
        config_in.beat_count  = BEAT_COUNT_W'(beats);
        config_in.lane_enable = mask;
        job_mask      = mask;
        job_beats     = beats;
        beats_left    = beats;
        awaiting_done = 1'b1;
        for (int i = 0; i < NUM_LANES; i++) begin
            words_to_send[i] = mask[i] ? beats : 0;
        end
        cycles = 0;
        while (awaiting_done) begin
            assert (cycles < 4000) else report_failure("Timeout waiting for done");
            tick();
            config_in = '0;
            cycles++;
        end
        assert (request_count == expected_requests)
            else report_mismatch($sformatf("%0d config requests seen", request_count));
        for (int i = 0; i < NUM_LANES; i++) begin
            assert (lane_credits[i] == FIFO_DEPTH && sent_q[i].size() == 0)
                else report_failure($sformatf("Lane %0d credits not returned after job", i));
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int                   beats;
        int                   idle;
        logic [NUM_LANES-1:0] mask;
        areset_generator = 1'b1;
        descriptor_valid = 1'b0;
        config_in        = '0;
        out_credit       = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_in[i]       = '0;
            lane_credits[i]  = FIFO_DEPTH;
            words_to_send[i] = 0;
        end
        outstanding       = 0;
        withhold          = 0;
        job_mask          = '0;
        job_beats         = 0;
        beats_left        = 0;
        awaiting_done     = 1'b0;
        packet_last_cycle = 1'b0;
        request_count     = 0;
        tick();
        tick();
        areset_generator = 1'b0;
        for (int job = 0; job < NUM_JOBS; job++) begin
            // Job 2 always covers the empty job
            beats = (job == 2) ? 0 : ($random(seed) & 32'h7fff_ffff) % (MAX_BEATS + 1);
            mask  = NUM_LANES'($random(seed));
            if (mask == '0) begin
                mask[job % NUM_LANES] = 1'b1;
            end
            run_job(beats, mask);
            idle = $random(seed) & 7;
            for (int d = 0; d < idle; d++) begin
                tick();
            end
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            assert (lane_credits[i] == FIFO_DEPTH)
                else report_failure($sformatf("Lane %0d ended without all credits", i));
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== tb.f ====
merge_pkg.sv
lane_fifo.sv
lane_input_stage.sv
merge_control.sv
merge_output_stage.sv
merge_data_generator.sv
merge_checker.sv
tb_merge_data_generator.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_merge_data_generator
FILELIST  := tb.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
